/* build.f */
+incdir+.
io_bus_pkg.sv
io_resp_merge.sv
io_bridge_128_to_32.sv
io_scratch_regs.sv
io_event_counter.sv
io_subsystem.sv
tb_io_subsystem.sv

/* io_bridge_128_to_32.sv */
`timescale 1ns/1ns
`default_nettype none

// Narrowing bridge between the 128-bit CPU port and the 32-bit devices.
// The CPU sees the whole device group as a single registered device.
module io_bridge_128_to_32 (
	input wire logic clk_i,
	input wire logic rst_i,
	input io_bus_pkg::io_req128_t cpu_req_i,
	output io_bus_pkg::io_resp128_t cpu_resp_o,
	output io_bus_pkg::io_req32_t dev_req_o,
	input io_bus_pkg::io_resp32_t dev_resp_i
);

	// Byte index of the access within the 16-byte wide word
	logic [3:0] lane;

	// ========================================
	// Lane decode from the wide byte select
	// ========================================

	// Lowest set byte for single bytes, pairs, halves and the full word
	always_comb begin
		case (cpu_req_i.sel)
			16'h0001: lane = 4'h0;
			16'h0002: lane = 4'h1;
			16'h0004: lane = 4'h2;
			16'h0008: lane = 4'h3;
			16'h0010: lane = 4'h4;
			16'h0020: lane = 4'h5;
			16'h0040: lane = 4'h6;
			16'h0080: lane = 4'h7;
			16'h0100: lane = 4'h8;
			16'h0200: lane = 4'h9;
			16'h0400: lane = 4'hA;
			16'h0800: lane = 4'hB;
			16'h1000: lane = 4'hC;
			16'h2000: lane = 4'hD;
			16'h4000: lane = 4'hE;
			16'h8000: lane = 4'hF;
			16'h0003: lane = 4'h0;
			16'h000C: lane = 4'h2;
			16'h0030: lane = 4'h4;
			16'h00C0: lane = 4'h6;
			16'h0300: lane = 4'h8;
			16'h0C00: lane = 4'hA;
			16'h3000: lane = 4'hC;
			16'hC000: lane = 4'hE;
			16'h00FF: lane = 4'h0;
			16'hFF00: lane = 4'h8;
			16'hFFFF: lane = 4'h0;
			// Patterns outside the table fall back to lane 0
			default: lane = 4'h0;
		endcase
	end

	// ========================================
	// Downstream request register
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			dev_req_o <= '0;
			dev_req_o.padr <= '1;
		end
		else if (cpu_req_i.cyc) begin
			dev_req_o.cyc <= 1'b1;
			dev_req_o.stb <= cpu_req_i.stb;
			dev_req_o.we <= cpu_req_i.we;
			dev_req_o.tid <= cpu_req_i.tid;
			// Low nibble of the address becomes the byte lane
			dev_req_o.padr <= {cpu_req_i.padr[31:4], lane};
			// Fold the four select nibbles onto the narrow bus
			dev_req_o.sel <= cpu_req_i.sel[15:12] | cpu_req_i.sel[11:8]
				| cpu_req_i.sel[7:4] | cpu_req_i.sel[3:0];
			// Bring the addressed 32-bit word down to bit 0
			dev_req_o.dat <= 32'(cpu_req_i.dat >> {lane[3:2], 5'd0});
		end
		else begin
			// Idle bus, the all ones address matches no device
			dev_req_o.cyc <= 1'b0;
			dev_req_o.stb <= 1'b0;
			dev_req_o.we <= 1'b0;
			dev_req_o.sel <= '0;
			dev_req_o.padr <= '1;
			dev_req_o.dat <= '0;
		end
	end

	// ========================================
	// Upstream response register
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cpu_resp_o <= '0;
		end
		else begin
			cpu_resp_o.ack <= dev_resp_i.ack;
			cpu_resp_o.tid <= dev_resp_i.tid;
			cpu_resp_o.adr <= dev_resp_i.adr;
			// The read word shows up in every lane, the CPU picks its own
			cpu_resp_o.dat <= {4{dev_resp_i.dat}};
		end
	end

endmodule

`default_nettype wire

/* io_bus_macros.svh */
`ifndef IO_BUS_MACROS_SVH
`define IO_BUS_MACROS_SVH

// ========================================
// I/O bridge address map and channel count
// ========================================

// Number of devices hanging off the narrow side of the bridge
`define IO_CHANNELS 2

// Device base addresses, each device owns a 64 KB window
`define IO_SCRATCH_BASE 32'hFFD0_0000
`define IO_COUNTER_BASE 32'hFFD1_0000

// Address bits compared against a device base
`define IO_DEV_MASK 32'hFFFF_0000

`endif

/* io_bus_pkg.sv */
`default_nettype none

package io_bus_pkg;

	// ========================================
	// Widths that carry a meaning on the bus
	// ========================================

	// Physical address, one 32-bit word
	typedef logic [31:0] io_adr_t;
	// Device side data word
	typedef logic [31:0] io_dat32_t;
	// CPU side data, four 32-bit lanes
	typedef logic [127:0] io_dat128_t;
	// CPU byte select, one bit per byte of the wide bus
	typedef logic [15:0] io_sel16_t;
	// Device byte select
	typedef logic [3:0] io_sel4_t;
	// Transaction tag, echoed back unchanged
	typedef logic [7:0] io_tid_t;

	// ========================================
	// Request and response bundles
	// ========================================

	// Request from the CPU on the wide port
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		io_sel16_t sel;
		io_adr_t padr;
		io_dat128_t dat;
		io_tid_t tid;
	} io_req128_t;

	// Narrowed request as seen by every device
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		io_sel4_t sel;
		io_adr_t padr;
		io_dat32_t dat;
		io_tid_t tid;
	} io_req32_t;

	// Device response, all zeros while the device is not acking
	typedef struct packed {
		logic ack;
		io_tid_t tid;
		io_adr_t adr;
		io_dat32_t dat;
	} io_resp32_t;

	// Response returned to the CPU with the read word in all lanes
	typedef struct packed {
		logic ack;
		io_tid_t tid;
		io_adr_t adr;
		io_dat128_t dat;
	} io_resp128_t;

	// Device access state, DONE holds off a second ack on the same cyc
	typedef enum logic {
		IDLE,
		DONE
	} io_dev_state_e;

	// Replace the bytes of a register word that the select enables
	function automatic io_dat32_t byte_merge(io_dat32_t old_dat, io_dat32_t wr_dat, io_sel4_t sel);
		io_dat32_t res;
		res = old_dat;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[8*b +: 8] = wr_dat[8*b +: 8];
		end
		return res;
	endfunction

endpackage

`default_nettype wire

/* io_event_counter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "io_bus_macros.svh"

// Free running event counter with an enable bit and a loadable count.
// Word 0 is the control register, word 1 is the count.
module io_event_counter (
	input wire logic clk_i,
	input wire logic rst_i,
	input io_bus_pkg::io_req32_t req_i,
	output io_bus_pkg::io_resp32_t resp_o
);

	// Control word, bit 0 enables counting
	io_bus_pkg::io_dat32_t ctrl;
	// Current count
	io_bus_pkg::io_dat32_t count;
	// Acked once per cyc
	io_bus_pkg::io_dev_state_e state;
	logic hit;
	logic access;
	// Word within the window, 0 control and 1 count
	logic [1:0] word;
	// Read mux result
	io_bus_pkg::io_dat32_t rd_dat;

	assign hit = (req_i.padr & `IO_DEV_MASK) == `IO_COUNTER_BASE;
	assign access = req_i.cyc && req_i.stb && hit && (state == io_bus_pkg::IDLE);
	assign word = req_i.padr[3:2];

	// Unused words read back as zero
	always_comb begin
		case (word)
			2'd0: rd_dat = ctrl;
			2'd1: rd_dat = count;
			default: rd_dat = '0;
		endcase
	end

	// ========================================
	// Access state and response
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= io_bus_pkg::IDLE;
			resp_o <= '0;
		end
		else begin
			resp_o <= '0;
			if (access) begin
				state <= io_bus_pkg::DONE;
				resp_o.ack <= 1'b1;
				resp_o.tid <= req_i.tid;
				resp_o.adr <= req_i.padr;
				resp_o.dat <= rd_dat;
			end
			else if (!req_i.cyc)
				state <= io_bus_pkg::IDLE;
		end
	end

	// Control and count registers, a load wins over the increment
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ctrl <= '0;
			count <= '0;
		end
		else begin
			if (access && req_i.we && word == 2'd0)
				ctrl <= io_bus_pkg::byte_merge(ctrl, req_i.dat, req_i.sel);
			if (access && req_i.we && word == 2'd1)
				count <= io_bus_pkg::byte_merge(count, req_i.dat, req_i.sel);
			else if (ctrl[0])
				count <= count + 32'd1;
		end
	end

endmodule

`default_nettype wire

/* io_resp_merge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "io_bus_macros.svh"

// Collects the per-channel device responses into a single registered
// response. Only one device answers at a time and an idle device drives
// all zeros, so a plain OR of the channels is the selected response.
module io_resp_merge (
	input wire logic clk_i,
	input wire logic rst_i,
	input io_bus_pkg::io_resp32_t [`IO_CHANNELS-1:0] resp_i,
	output io_bus_pkg::io_resp32_t resp_o
);

	// ========================================
	// Combine the channels
	// ========================================

	// OR of every channel response
	io_bus_pkg::io_resp32_t resp_or;

	always_comb begin
		resp_or = '0;
		// Fold each channel in, the zero idle value leaves the others intact
		for (int ch = 0; ch < `IO_CHANNELS; ch++) begin
			resp_or = resp_or | resp_i[ch];
		end
	end

	// ========================================
	// Output register
	// ========================================

	// One pipeline stage between the devices and the bridge
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			// No ack is pending after reset
			resp_o <= '0;
		end
		else begin
			resp_o <= resp_or;
		end
	end

endmodule

`default_nettype wire

/* io_scratch_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "io_bus_macros.svh"

// Bank of eight 32-bit read/write scratch registers with byte enables
module io_scratch_regs (
	input wire logic clk_i,
	input wire logic rst_i,
	input io_bus_pkg::io_req32_t req_i,
	output io_bus_pkg::io_resp32_t resp_o
);

	// Register storage
	io_bus_pkg::io_dat32_t regs [8];
	// Acked once per cyc
	io_bus_pkg::io_dev_state_e state;
	// Address falls inside this device's window
	logic hit;
	// New request that has not been answered yet
	logic access;
	// Register picked by address bits 4:2
	logic [2:0] idx;

	assign hit = (req_i.padr & `IO_DEV_MASK) == `IO_SCRATCH_BASE;
	assign access = req_i.cyc && req_i.stb && hit && (state == io_bus_pkg::IDLE);
	assign idx = req_i.padr[4:2];

	// ========================================
	// Access state and response
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= io_bus_pkg::IDLE;
			resp_o <= '0;
		end
		else begin
			// Zero unless acking so the merge can OR the channels
			resp_o <= '0;
			if (access) begin
				state <= io_bus_pkg::DONE;
				resp_o.ack <= 1'b1;
				resp_o.tid <= req_i.tid;
				resp_o.adr <= req_i.padr;
				resp_o.dat <= regs[idx];
			end
			// Rearm once the CPU has dropped its cycle
			else if (!req_i.cyc)
				state <= io_bus_pkg::IDLE;
		end
	end

	// Write only the bytes the select enables
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int r = 0; r < 8; r++)
				regs[r] <= '0;
		end
		else if (access && req_i.we) begin
			regs[idx] <= io_bus_pkg::byte_merge(regs[idx], req_i.dat, req_i.sel);
		end
	end

endmodule

`default_nettype wire

/* io_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "io_bus_macros.svh"

// I/O subsystem top. The CPU reaches the scratch bank and the event
// counter through one registered bridge, four cycles per access.
module io_subsystem (
	input wire logic clk_i,
	input wire logic rst_i,
	input io_bus_pkg::io_req128_t cpu_req_i,
	output io_bus_pkg::io_resp128_t cpu_resp_o
);

	// Narrow request broadcast to every device
	io_bus_pkg::io_req32_t dev_req;
	// One response per device channel
	io_bus_pkg::io_resp32_t [`IO_CHANNELS-1:0] ch_resp;
	// Registered OR of the channel responses
	io_bus_pkg::io_resp32_t merged_resp;

	io_bridge_128_to_32 u_bridge (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cpu_req_i(cpu_req_i),
		.cpu_resp_o(cpu_resp_o),
		.dev_req_o(dev_req),
		.dev_resp_i(merged_resp)
	);

	// Channel 0, scratch registers
	io_scratch_regs u_scratch (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.req_i(dev_req),
		.resp_o(ch_resp[0])
	);

	// Channel 1, event counter
	io_event_counter u_counter (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.req_i(dev_req),
		.resp_o(ch_resp[1])
	);

	io_resp_merge u_merge (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.resp_i(ch_resp),
		.resp_o(merged_resp)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the I/O subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_io_subsystem -f build.f -o sim_io_subsystem
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_io_subsystem)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^SIMULATION PASSED$"; then
	exit 0
fi
exit 1

/* tb_io_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "io_bus_macros.svh"

module tb_io_subsystem;

	// Result check kinds, header only skips the data field
	localparam logic [1:0] CHK_FULL = 2'd0;
	localparam logic [1:0] CHK_HDR = 2'd1;
	localparam logic [1:0] CHK_DIFF = 2'd2;
	localparam int RESET_CYCLES = 4;

	// One table row, expected response worked out before the run
	typedef struct packed {
		logic we;
		io_bus_pkg::io_adr_t padr;
		io_bus_pkg::io_sel16_t sel;
		io_bus_pkg::io_dat128_t dat;
		io_bus_pkg::io_resp128_t exp;
		logic [1:0] kind;
	} entry_t;

	logic clk_i = 1'b0;
	logic rst_i = 1'b1;
	io_bus_pkg::io_req128_t cpu_req = '0;
	io_bus_pkg::io_resp128_t cpu_resp;

	entry_t table_q [$];
	int drive_cyc [$];
	// Reference contents of the devices
	io_bus_pkg::io_dat32_t model_regs [8];
	io_bus_pkg::io_dat32_t model_ctrl;
	io_bus_pkg::io_dat32_t model_count;
	io_bus_pkg::io_dat32_t last_count;
	io_bus_pkg::io_dat32_t lfsr;
	int err_data;
	int err_lat;
	int err_tid;
	int err_proto;
	int cycle_cnt = 0;
	int cycle_limit;

	io_subsystem DUT (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cpu_req_i(cpu_req),
		.cpu_resp_o(cpu_resp)
	);

	always #2 clk_i = ~clk_i;

	// Run limit, the table length sets it
	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ========================================
	// Reference model helpers
	// ========================================

	// Galois step, one call per random bit
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h8020_0003;
		return b;
	endfunction

	function automatic io_bus_pkg::io_dat128_t rand128();
		io_bus_pkg::io_dat128_t d;
		for (int k = 0; k < 128; k++)
			d = {d[126:0], lfsr_bit()};
		return d;
	endfunction

	// Lowest set byte for single bytes, aligned pairs, halves and all 16 bytes, else 0
	function automatic logic [3:0] lane_of(input io_bus_pkg::io_sel16_t sel);
		int n;
		int lo;
		io_bus_pkg::io_sel16_t run;
		n = $countones(sel);
		lo = 0;
		for (int b = 15; b >= 0; b--) begin
			if (sel[b])
				lo = b;
		end
		for (int b = 0; b < 16; b++)
			run[b] = (b >= lo) && (b < lo + n);
		if ((n == 1 || n == 2 || n == 8 || n == 16) && (lo % n == 0) && (sel == run))
			return 4'(lo);
		return 4'h0;
	endfunction

	// Byte b of the wide select lands on byte b mod 4 of the narrow one
	function automatic io_bus_pkg::io_sel4_t fold_sel(input io_bus_pkg::io_sel16_t sel);
		io_bus_pkg::io_sel4_t f;
		f = '0;
		for (int b = 0; b < 16; b++)
			f[b % 4] = f[b % 4] | sel[b];
		return f;
	endfunction

	function automatic io_bus_pkg::io_dat32_t merge_bytes(input io_bus_pkg::io_dat32_t old,
		input io_bus_pkg::io_dat32_t wr, input io_bus_pkg::io_sel4_t sel);
		io_bus_pkg::io_dat32_t mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old & ~mask) | (wr & mask);
	endfunction

	// Append one access and update the model with its effect
	task automatic add_entry(input logic we, input io_bus_pkg::io_adr_t padr,
		input io_bus_pkg::io_sel16_t sel, input io_bus_pkg::io_dat128_t dat,
		input logic [1:0] kind);
		entry_t e;
		logic [3:0] lane;
		io_bus_pkg::io_adr_t dpadr;
		io_bus_pkg::io_sel4_t nsel;
		io_bus_pkg::io_dat32_t wword;
		io_bus_pkg::io_dat32_t old;
		lane = lane_of(sel);
		dpadr = {padr[31:4], lane};
		nsel = fold_sel(sel);
		wword = dat[32*lane[3:2] +: 32];
		if ((dpadr & `IO_DEV_MASK) == `IO_SCRATCH_BASE) begin
			old = model_regs[dpadr[4:2]];
			if (we)
				model_regs[dpadr[4:2]] = merge_bytes(old, wword, nsel);
		end
		else if (dpadr[3:2] == 2'd0) begin
			old = model_ctrl;
			if (we)
				model_ctrl = merge_bytes(old, wword, nsel);
		end
		else begin
			old = model_count;
			if (we)
				model_count = merge_bytes(old, wword, nsel);
		end
		e.we = we;
		e.padr = padr;
		e.sel = sel;
		e.dat = dat;
		e.kind = kind;
		// Devices return the old word, a write included
		e.exp.ack = 1'b1;
		e.exp.tid = io_bus_pkg::io_tid_t'(table_q.size());
		e.exp.adr = dpadr;
		e.exp.dat = {4{old}};
		table_q.push_back(e);
	endtask

	// Random write, then a read of the same word through a single byte lane
	task automatic write_then_read(input io_bus_pkg::io_adr_t padr,
		input io_bus_pkg::io_sel16_t sel);
		add_entry(1'b1, padr, sel, rand128(), CHK_FULL);
		add_entry(1'b0, padr, 16'h0001 << lane_of(sel), '0, CHK_FULL);
	endtask

	task automatic build_table();
		for (int r = 0; r < 8; r++)
			model_regs[r] = '0;
		model_ctrl = '0;
		model_count = '0;
		// Reset state of every scratch word and the counter control
		for (int r = 0; r < 8; r++)
			add_entry(1'b0, `IO_SCRATCH_BASE + 32'(16 * (r / 4)),
				16'h0001 << (4 * (r % 4)), '0, CHK_FULL);
		add_entry(1'b0, `IO_COUNTER_BASE, 16'h0001, '0, CHK_FULL);
		// Full words on each lane
		write_then_read(`IO_SCRATCH_BASE, 16'h000F);
		write_then_read(`IO_SCRATCH_BASE + 32'h10, 16'h00F0);
		write_then_read(`IO_SCRATCH_BASE, 16'h0F00);
		write_then_read(`IO_SCRATCH_BASE + 32'h10, 16'hF000);
		write_then_read(`IO_SCRATCH_BASE, 16'hFF00);
		write_then_read(`IO_SCRATCH_BASE + 32'h10, 16'hFFFF);
		// Single bytes and byte pairs over earlier contents
		write_then_read(`IO_SCRATCH_BASE, 16'h0010);
		write_then_read(`IO_SCRATCH_BASE, 16'h0C00);
		write_then_read(`IO_SCRATCH_BASE + 32'h10, 16'h8000);
		write_then_read(`IO_SCRATCH_BASE + 32'h10, 16'h0003);
		write_then_read(`IO_SCRATCH_BASE, 16'h0020);
		write_then_read(`IO_SCRATCH_BASE + 32'h10, 16'h0300);
		// Count loaded byte by byte while disabled, then read twice
		add_entry(1'b1, `IO_COUNTER_BASE, 16'h0010, rand128(), CHK_FULL);
		add_entry(1'b1, `IO_COUNTER_BASE, 16'h0020, rand128(), CHK_FULL);
		add_entry(1'b1, `IO_COUNTER_BASE, 16'h00C0, rand128(), CHK_FULL);
		add_entry(1'b0, `IO_COUNTER_BASE, 16'h0010, '0, CHK_FULL);
		add_entry(1'b0, `IO_COUNTER_BASE, 16'h0010, '0, CHK_FULL);
		// Enable and watch the count advance between two reads
		add_entry(1'b1, `IO_COUNTER_BASE, 16'h0001, 128'h1, CHK_FULL);
		add_entry(1'b0, `IO_COUNTER_BASE, 16'h0010, '0, CHK_HDR);
		add_entry(1'b0, `IO_COUNTER_BASE, 16'h0010, '0, CHK_DIFF);
	endtask

	// ========================================
	// Compare tasks
	// ========================================

	task automatic check_resp(input io_bus_pkg::io_resp128_t got,
		input io_bus_pkg::io_resp128_t exp, input logic with_dat);
		if (got.ack !== exp.ack || got.adr !== exp.adr || (with_dat && got.dat !== exp.dat)) begin
			err_data++;
			$display("Mismatch at %0t: response adr %h dat %h", $time, got.adr, got.dat);
			$display("  expected adr %h dat %h", exp.adr, exp.dat);
		end
	endtask

	task automatic check_latency(input int got);
		if (got != 4) begin
			err_lat++;
			$display("Mismatch at %0t: ack after %0d cycles, expected 4", $time, got);
		end
	endtask

	task automatic check_tid(input io_bus_pkg::io_tid_t got, input io_bus_pkg::io_tid_t exp);
		if (got !== exp) begin
			err_tid++;
			$display("Mismatch at %0t: tid %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_word(input io_bus_pkg::io_dat32_t got, input io_bus_pkg::io_dat32_t exp);
		if (got !== exp) begin
			err_data++;
			$display("Mismatch at %0t: count advanced by %0d, expected %0d", $time, got, exp);
		end
	endtask

	// ========================================
	// Access sequence
	// ========================================

	task automatic run_entry(input int i);
		io_bus_pkg::io_req128_t req;
		io_bus_pkg::io_resp128_t got;
		int lat;
		req = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = table_q[i].we;
		req.sel = table_q[i].sel;
		req.padr = table_q[i].padr;
		req.dat = table_q[i].dat;
		req.tid = io_bus_pkg::io_tid_t'(i);
		lat = 0;
		@(posedge clk_i);
		cpu_req <= req;
		drive_cyc.push_back(cycle_cnt);
		// Latency counts rising edges from the drive edge to the ack
		do begin
			@(posedge clk_i);
			lat++;
			@(negedge clk_i);
		end while (!cpu_resp.ack);
		got = cpu_resp;
		check_latency(lat);
		check_tid(got.tid, table_q[i].exp.tid);
		check_resp(got, table_q[i].exp, table_q[i].kind == CHK_FULL);
		if (table_q[i].kind == CHK_DIFF)
			check_word(got.dat[31:0] - last_count,
				io_bus_pkg::io_dat32_t'(drive_cyc[i] - drive_cyc[i-1]));
		last_count = got.dat[31:0];
		@(posedge clk_i);
		cpu_req.cyc <= 1'b0;
		cpu_req.stb <= 1'b0;
		@(negedge clk_i);
		if (cpu_resp.ack) begin
			err_proto++;
			$display("Access %0d at %0t: ack stayed high for a second cycle", i, $time);
		end
	endtask

	initial begin
		int total;
		err_data = 0;
		err_lat = 0;
		err_tid = 0;
		err_proto = 0;
		lfsr = 32'hdad5_7e36;
		build_table();
		cycle_limit = 12 * table_q.size() + RESET_CYCLES + 2;
		repeat (RESET_CYCLES) @(posedge clk_i);
		rst_i <= 1'b0;
		for (int i = 0; i < table_q.size(); i++)
			run_entry(i);
		total = err_data + err_lat + err_tid + err_proto;
		$display("Errors: data %0d, latency %0d, tid %0d, protocol %0d",
			err_data, err_lat, err_tid, err_proto);
		if (total == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
